// ==== audio_consts.svh ====
`ifndef AUDIO_CONSTS_SVH
`define AUDIO_CONSTS_SVH

`default_nettype none

// ======================================================================
// Audio path widths
// ======================================================================

// Sample width for both channels
`define AUDIO_W 16

// Cross-mix level
`define MIX_W 2

// Top bit mutes, low four bits give the right shift
`define ATT_W 5

// ======================================================================
// Host commands
// ======================================================================

`define CMD_LED 8'h25
`define CMD_VOLUME 8'h26

// Duration counter for sync polarity detection
`define SYNC_CNT_W 16

`default_nettype wire

`endif

// ==== audio_pkg.sv ====
`include "audio_consts.svh"

`default_nettype none

package audio_pkg;

	// One audio sample, signedness carried separately
	typedef logic [`AUDIO_W-1:0] sample_t;

	// 0 none, 1 one eighth, 2 one quarter, 3 half each
	typedef logic [`MIX_W-1:0] mix_t;

	// {mute, shift[3:0]}
	typedef logic [`ATT_W-1:0] att_t;

	typedef logic [7:0] cmd_t;
	typedef logic [15:0] io_word_t;

	// Upper byte is the override mask, lower byte the LED state
	typedef logic [15:0] led_t;

	// Right shift of a sample, arithmetic when the stream is signed
	function automatic sample_t sample_shr(
		input sample_t v,
		input logic [3:0] k,
		input logic sgn
	);
		sample_t res;
		if (sgn)
			res = sample_t'($signed(v) >>> k);
		else
			res = v >> k;
		return res;
	endfunction

endpackage

`default_nettype wire

// ==== io_cmd_decoder.sv ====
`include "audio_consts.svh"

`default_nettype none

module io_cmd_decoder (
	input wire logic FPGA_CLK2_50,
	input wire logic resetd,
	input wire logic io_clk,
	input wire logic io_uio,
	input wire audio_pkg::io_word_t io_din,
	output audio_pkg::att_t vol_att,
	output audio_pkg::led_t led_override
);
	import audio_pkg::*;

	logic clk_s1;
	logic clk_s2;
	logic clk_d;
	logic uio_s1;
	logic uio_s2;
	logic strobe;
	logic has_cmd;
	io_word_t din_s1;
	io_word_t din_s2;
	cmd_t cmd;

	// ==================================================================
	// Host line synchronizers and strobe edge detect
	// ==================================================================
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			clk_s1 <= 1'b0;
			clk_s2 <= 1'b0;
			clk_d <= 1'b0;
			uio_s1 <= 1'b0;
			uio_s2 <= 1'b0;
			strobe <= 1'b0;
		end else begin
			clk_s1 <= io_clk;
			clk_s2 <= clk_s1;
			clk_d <= clk_s2;
			uio_s1 <= io_uio;
			uio_s2 <= uio_s1;
			// One cycle per rising strobe
			strobe <= clk_s2 & ~clk_d;
		end
	end

	// Data word is held stable around the strobe
	always_ff @(posedge FPGA_CLK2_50) begin
		din_s1 <= io_din;
		din_s2 <= din_s1;
	end

	// First word after enable is the command byte
	always_ff @(posedge FPGA_CLK2_50) begin
		if (uio_s2 && strobe && !has_cmd)
			cmd <= din_s2[7:0];
	end

	// ==================================================================
	// Command state and settings
	// ==================================================================
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			has_cmd <= 1'b0;
			vol_att <= '0;
			led_override <= '0;
		end else if (!uio_s2) begin
			has_cmd <= 1'b0;
		end else if (strobe) begin
			if (!has_cmd) begin
				has_cmd <= 1'b1;
			end else begin
				case (cmd)
					`CMD_VOLUME: vol_att <= din_s2[`ATT_W-1:0];
					`CMD_LED: led_override <= din_s2;
					// Anything else is ignored
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== stereo_mixer.sv ====
`default_nettype none

module stereo_mixer (
	input wire logic FPGA_CLK2_50,
	input wire logic resetd,
	input wire audio_pkg::sample_t audio_ls,
	input wire audio_pkg::sample_t audio_rs,
	input wire logic audio_s,
	input wire audio_pkg::mix_t audio_mix,
	output audio_pkg::sample_t mix_l,
	output audio_pkg::sample_t mix_r,
	output logic mix_signed
);
	import audio_pkg::*;

	sample_t next_l;
	sample_t next_r;

	// Blend one channel with the other, sums wrap at sample width
	function automatic sample_t mix_chan(
		input sample_t own,
		input sample_t other,
		input mix_t lvl,
		input logic sgn
	);
		sample_t res;
		case (lvl)
			2'd1: res = own - sample_shr(own, 4'd3, sgn) + sample_shr(other, 4'd3, sgn);
			2'd2: res = own - sample_shr(own, 4'd2, sgn) + sample_shr(other, 4'd2, sgn);
			2'd3: res = sample_shr(own, 4'd1, sgn) + sample_shr(other, 4'd1, sgn);
			default: res = own;
		endcase
		return res;
	endfunction

	always_comb begin
		next_l = mix_chan(audio_ls, audio_rs, audio_mix, audio_s);
		next_r = mix_chan(audio_rs, audio_ls, audio_mix, audio_s);
	end

	// Stage one register, signedness travels with the samples
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			mix_l <= '0;
			mix_r <= '0;
			mix_signed <= 1'b0;
		end else begin
			mix_l <= next_l;
			mix_r <= next_r;
			mix_signed <= audio_s;
		end
	end

endmodule

`default_nettype wire

// ==== volume_stage.sv ====
`include "audio_consts.svh"

`default_nettype none

module volume_stage (
	input wire logic FPGA_CLK2_50,
	input wire logic resetd,
	input wire audio_pkg::sample_t mix_l,
	input wire audio_pkg::sample_t mix_r,
	input wire logic mix_signed,
	input wire audio_pkg::att_t vol_att,
	output audio_pkg::sample_t audio_l,
	output audio_pkg::sample_t audio_r
);
	import audio_pkg::*;

	logic mute;
	logic [3:0] shift;

	assign mute = vol_att[`ATT_W-1];
	assign shift = vol_att[`ATT_W-2:0];

	// Stage two register, attenuation takes effect the same cycle
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			audio_l <= '0;
			audio_r <= '0;
		end else if (mute) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= sample_shr(mix_l, shift, mix_signed);
			audio_r <= sample_shr(mix_r, shift, mix_signed);
		end
	end

endmodule

`default_nettype wire

// ==== sync_polarity_fix.sv ====
`include "audio_consts.svh"

`default_nettype none

module sync_polarity_fix (
	input wire logic FPGA_CLK2_50,
	input wire logic resetd,
	input wire logic sync_in,
	output logic sync_out
);
	logic s1;
	logic s2;
	logic pol;
	logic [`SYNC_CNT_W-1:0] cnt;
	logic [`SYNC_CNT_W-1:0] hi_len;
	logic [`SYNC_CNT_W-1:0] lo_len;

	// Raw input, flipped when the line idles high
	assign sync_out = sync_in ^ pol;

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			s1 <= 1'b0;
			s2 <= 1'b0;
			cnt <= '0;
			hi_len <= '0;
			lo_len <= '0;
			pol <= 1'b0;
		end else begin
			s1 <= sync_in;
			s2 <= s1;

			// Falling edge closes a high period, rising edge a low one
			if (s2 && !s1)
				hi_len <= cnt;
			if (!s2 && s1)
				lo_len <= cnt;

			// Restart on every level change, saturate otherwise
			if (s1 != s2)
				cnt <= '0;
			else if (cnt != '1)
				cnt <= cnt + 1'b1;

			pol <= hi_len > lo_len;
		end
	end

endmodule

`default_nettype wire

// ==== hps_audio_top.sv ====
`default_nettype none

module hps_audio_top (
	input wire logic FPGA_CLK2_50,
	input wire logic resetd,
	input wire logic io_clk,
	input wire logic io_uio,
	input wire audio_pkg::io_word_t io_din,
	input wire audio_pkg::sample_t audio_ls,
	input wire audio_pkg::sample_t audio_rs,
	input wire logic audio_s,
	input wire audio_pkg::mix_t audio_mix,
	input wire logic hs_in,
	input wire logic vs_in,
	output audio_pkg::sample_t audio_l,
	output audio_pkg::sample_t audio_r,
	output audio_pkg::led_t led_override,
	output logic hs_out,
	output logic vs_out
);
	import audio_pkg::*;

	att_t vol_att;
	sample_t mix_l;
	sample_t mix_r;
	logic mix_signed;

	// ==================================================================
	// Host commands
	// ==================================================================
	io_cmd_decoder cmd_dec (
		.FPGA_CLK2_50(FPGA_CLK2_50),
		.resetd(resetd),
		.io_clk(io_clk),
		.io_uio(io_uio),
		.io_din(io_din),
		.vol_att(vol_att),
		.led_override(led_override)
	);

	// ==================================================================
	// Audio pipeline, two cycles input to output
	// ==================================================================
	stereo_mixer mixer (
		.FPGA_CLK2_50(FPGA_CLK2_50),
		.resetd(resetd),
		.audio_ls(audio_ls),
		.audio_rs(audio_rs),
		.audio_s(audio_s),
		.audio_mix(audio_mix),
		.mix_l(mix_l),
		.mix_r(mix_r),
		.mix_signed(mix_signed)
	);

	volume_stage volume (
		.FPGA_CLK2_50(FPGA_CLK2_50),
		.resetd(resetd),
		.mix_l(mix_l),
		.mix_r(mix_r),
		.mix_signed(mix_signed),
		.vol_att(vol_att),
		.audio_l(audio_l),
		.audio_r(audio_r)
	);

	// Sync lines leave active high
	sync_polarity_fix hs_fix (
		.FPGA_CLK2_50(FPGA_CLK2_50),
		.resetd(resetd),
		.sync_in(hs_in),
		.sync_out(hs_out)
	);

	sync_polarity_fix vs_fix (
		.FPGA_CLK2_50(FPGA_CLK2_50),
		.resetd(resetd),
		.sync_in(vs_in),
		.sync_out(vs_out)
	);

endmodule

`default_nettype wire

// ==== hps_audio_assert.sv ====
`include "audio_consts.svh"

`default_nettype none

module hps_audio_assert (
	input wire logic FPGA_CLK2_50,
	input wire logic resetd,
	input wire audio_pkg::att_t vol_att,
	input wire audio_pkg::sample_t audio_l,
	input wire audio_pkg::sample_t audio_r
);
	timeunit 1ns;
	timeprecision 1ps;

	// Mute zeroes both channels on the next edge
	mute_zero: assert property (@(posedge FPGA_CLK2_50) disable iff (resetd)
		vol_att[`ATT_W-1] |=> (audio_l == '0 && audio_r == '0))
		else $error("mute did not clear the audio outputs");

	// Reset clears the output registers
	reset_zero: assert property (@(posedge FPGA_CLK2_50)
		resetd |=> (audio_l == '0 && audio_r == '0))
		else $error("audio outputs not cleared by reset");

	known_att: assert property (@(posedge FPGA_CLK2_50) disable iff (resetd)
		!$isunknown(vol_att))
		else $error("attenuation setting is unknown");

endmodule

`default_nettype wire

// ==== tb_hps_audio.sv ====
`include "audio_consts.svh"

`default_nettype none

module tb_hps_audio;
	timeunit 1ns;
	timeprecision 1ps;

	import audio_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 10;
	localparam int MIX_SAMPLES = 100;
	localparam int VOL_CMDS = 12;
	localparam int VOL_SAMPLES = 64;
	// Enable lead, up to five words of 12 cycles, release and settle
	localparam int CMD_CYCLES = 16 + 12 * 5;
	localparam int SYNC_LEARN = 180;
	localparam int SYNC_CHECK = 120;
	localparam int TOTAL_CYCLES = RESET_CYCLES + 4 + 8 * (MIX_SAMPLES + 2)
		+ (VOL_CMDS + 6) * (CMD_CYCLES + VOL_SAMPLES + 2)
		+ 2 * (SYNC_LEARN + SYNC_CHECK);

	logic FPGA_CLK2_50;
	logic resetd;
	logic io_clk;
	logic io_uio;
	io_word_t io_din;
	sample_t audio_ls;
	sample_t audio_rs;
	logic audio_s;
	mix_t audio_mix;
	logic hs_in;
	logic vs_in;
	sample_t audio_l;
	sample_t audio_r;
	led_t led_override;
	logic hs_out;
	logic vs_out;

	att_t model_att;
	led_t model_led;
	sample_t exp_l_q[$];
	sample_t exp_r_q[$];
	io_word_t data_words[$];
	int err_sample;
	int err_led;
	int err_sync;

	hps_audio_top dut0 (
		.FPGA_CLK2_50(FPGA_CLK2_50),
		.resetd(resetd),
		.io_clk(io_clk),
		.io_uio(io_uio),
		.io_din(io_din),
		.audio_ls(audio_ls),
		.audio_rs(audio_rs),
		.audio_s(audio_s),
		.audio_mix(audio_mix),
		.hs_in(hs_in),
		.vs_in(vs_in),
		.audio_l(audio_l),
		.audio_r(audio_r),
		.led_override(led_override),
		.hs_out(hs_out),
		.vs_out(vs_out)
	);

	bind volume_stage hps_audio_assert vol_chk (
		.FPGA_CLK2_50(FPGA_CLK2_50),
		.resetd(resetd),
		.vol_att(vol_att),
		.audio_l(audio_l),
		.audio_r(audio_r)
	);

	initial begin
		FPGA_CLK2_50 = 1'b0;
		forever #(CLK_PERIOD / 2) FPGA_CLK2_50 = ~FPGA_CLK2_50;
	end

	initial begin
		#(TOTAL_CYCLES * CLK_PERIOD * 3 / 2);
		$display("Timeout: the run did not finish within %0d cycles", TOTAL_CYCLES * 3 / 2);
		$display("CHECKS FAILED");
		$finish;
	end

	// ==================================================================
	// Reference model
	// ==================================================================
	function automatic sample_t model_shr(input sample_t v, input int k, input logic sgn);
		logic [2*`AUDIO_W-1:0] wide;
		// Sign fill only for signed streams
		wide = {{`AUDIO_W{sgn & v[`AUDIO_W-1]}}, v};
		wide = wide >> k;
		return wide[`AUDIO_W-1:0];
	endfunction

	function automatic sample_t model_out(input sample_t own, input sample_t other,
		input mix_t lvl, input logic sgn, input att_t att);
		sample_t m;
		int k;
		if (lvl == 2'd0) begin
			m = own;
		end else if (lvl == 2'd3) begin
			m = model_shr(own, 1, sgn) + model_shr(other, 1, sgn);
		end else begin
			// An eighth at level 1, a quarter at level 2
			k = (lvl == 2'd1) ? 3 : 2;
			m = own - model_shr(own, k, sgn) + model_shr(other, k, sgn);
		end
		if (att[`ATT_W-1])
			m = '0;
		else
			m = model_shr(m, int'(att[`ATT_W-2:0]), sgn);
		return m;
	endfunction

	// ==================================================================
	// Compare tasks
	// ==================================================================
	task automatic check_sample(input string name, input sample_t got, input sample_t exp);
		if (got !== exp) begin
			err_sample++;
			$display("ERROR %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_led(input string name, input led_t got, input led_t exp);
		if (got !== exp) begin
			err_led++;
			$display("ERROR %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_sync(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			err_sync++;
			$display("ERROR %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	// ==================================================================
	// Stimulus
	// ==================================================================
	task automatic wait_cycles(input int n);
		repeat (n) @(negedge FPGA_CLK2_50);
	endtask

	// Word held 4 cycles around a strobe pulse of 4 cycles
	task automatic host_word(input io_word_t w);
		io_din = w;
		wait_cycles(4);
		io_clk = 1'b1;
		wait_cycles(4);
		io_clk = 1'b0;
		wait_cycles(4);
	endtask

	task automatic send_command(input cmd_t c);
		io_uio = 1'b1;
		wait_cycles(4);
		host_word({8'h00, c});
		while (data_words.size() > 0)
			host_word(data_words.pop_front());
		io_uio = 1'b0;
		wait_cycles(4);
		// Quiet time before samples resume
		wait_cycles(8);
	endtask

	// Signedness 0 or 1 fixed, 2 random per sample
	task automatic run_samples(input int n, input mix_t lvl, input int sgn_mode);
		logic [31:0] r;
		for (int i = 0; i < n + 2; i++) begin
			@(negedge FPGA_CLK2_50);
			if (i >= 2) begin
				check_sample("audio_l", audio_l, exp_l_q.pop_front());
				check_sample("audio_r", audio_r, exp_r_q.pop_front());
			end
			if (i < n) begin
				r = $urandom();
				audio_ls = r[31:16];
				audio_rs = r[15:0];
				r = $urandom();
				audio_s = (sgn_mode == 2) ? r[0] : (sgn_mode == 1);
				audio_mix = lvl;
				exp_l_q.push_back(model_out(audio_ls, audio_rs, lvl, audio_s, model_att));
				exp_r_q.push_back(model_out(audio_rs, audio_ls, lvl, audio_s, model_att));
			end
		end
	endtask

	// Short pulses every 24 cycles on hs, every 60 on vs
	task automatic run_sync(input logic active_high);
		for (int c = 0; c < SYNC_LEARN + SYNC_CHECK; c++) begin
			@(negedge FPGA_CLK2_50);
			if (c >= SYNC_LEARN) begin
				check_sync("hs_out", hs_out, active_high ? hs_in : ~hs_in);
				check_sync("vs_out", vs_out, active_high ? vs_in : ~vs_in);
			end
			// Pulse level equals active_high inside the pulse
			hs_in = ((c % 24) < 4) == active_high;
			vs_in = ((c % 60) < 6) == active_high;
		end
	endtask

	initial begin
		logic [31:0] r;
		void'($urandom(32'h30f4f303));
		resetd = 1'b1;
		io_clk = 1'b0;
		io_uio = 1'b0;
		io_din = '0;
		// Nonzero samples pass straight through at mix level 0
		audio_ls = 16'h8421;
		audio_rs = 16'h7bde;
		audio_s = 1'b0;
		audio_mix = '0;
		hs_in = 1'b1;
		vs_in = 1'b0;
		model_att = '0;
		model_led = '0;
		err_sample = 0;
		err_led = 0;
		err_sync = 0;

		// Reset values with live samples at the inputs
		wait_cycles(RESET_CYCLES);
		check_sample("audio_l", audio_l, '0);
		check_sample("audio_r", audio_r, '0);
		check_led("led_override", led_override, '0);
		check_sync("hs_out", hs_out, hs_in);
		check_sync("vs_out", vs_out, vs_in);
		resetd = 1'b0;
		wait_cycles(4);

		// Every mix level, unsigned then signed
		for (int lvl = 0; lvl < 4; lvl++)
			for (int s = 0; s < 2; s++)
				run_samples(MIX_SAMPLES, mix_t'(lvl), s);

		// Volume commands, mute on every other one
		for (int v = 0; v < VOL_CMDS; v++) begin
			r = $urandom();
			model_att = {v[0], r[3:0]};
			data_words.push_back({r[15:5], model_att});
			send_command(`CMD_VOLUME);
			run_samples(VOL_SAMPLES, mix_t'(r[17:16]), 2);
		end
		model_att = '0;
		data_words.push_back(16'h0000);
		send_command(`CMD_VOLUME);

		// ==============================================================
		// LED override and command framing
		// ==============================================================
		for (int n = 0; n < 2; n++) begin
			for (int w = 0; w < 3; w++) begin
				r = $urandom();
				data_words.push_back(r[15:0]);
			end
			model_led = r[15:0];
			send_command(`CMD_LED);
			check_led("led_override", led_override, model_led);
		end
		// Data words that look like command codes stay data
		data_words.push_back(16'h0026);
		data_words.push_back(16'h5a26);
		model_led = 16'h5a26;
		send_command(`CMD_LED);
		check_led("led_override", led_override, model_led);

		data_words.push_back(16'h1234);
		data_words.push_back(16'h0015);
		send_command(8'h33);
		check_led("led_override", led_override, model_led);
		run_samples(VOL_SAMPLES, 2'd3, 2);

		model_att = 5'h03;
		data_words.push_back(16'h0003);
		send_command(`CMD_VOLUME);
		run_samples(VOL_SAMPLES, 2'd1, 2);
		check_led("led_override", led_override, model_led);

		run_sync(1'b0);
		run_sync(1'b1);

		$display("Error counts: sample=%0d led=%0d sync=%0d", err_sample, err_led, err_sync);
		if (err_sample + err_led + err_sync == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
audio_pkg.sv
io_cmd_decoder.sv
stereo_mixer.sv
volume_stage.sv
sync_polarity_fix.sv
hps_audio_top.sv
hps_audio_assert.sv
tb_hps_audio.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_hps_audio
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

FAIL_MSG := CHECKS FAILED
PASS_MSG := ALL CHECKS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
